// File: Bender.yml
package:
  name: tlb

sources:
  - rtl/tlb_pkg.sv
  - rtl/tlb_way_ram.sv
  - rtl/tlb_reset_machine.sv
  - rtl/tlb_apb_regs.sv
  - rtl/tlb_lookup.sv
  - rtl/tlb_miss_queue.sv
  - rtl/tlb.sv
  - target: test
    files:
      - tests/tlb_tb.sv

// File: rtl/tlb.sv
`timescale 1ns/1ps

// Set-associative TLB with an APB register window and a miss queue
module tlb #(
	parameter int TLB_SETS = 16,
	parameter int TLB_WAYS = 2,
	parameter int MISS_DEPTH = 4
) (
	input logic clk,
	input logic rst_i,
	input tlb_pkg::apb_req_t apb_i,
	output tlb_pkg::apb_rsp_t apb_o,
	input logic paging_en_i,
	input tlb_pkg::tlb_req_t req_i,
	input logic req_v_i,
	output logic req_ready_o,
	output tlb_pkg::tlb_res_t res_o,
	output logic res_v_o,
	output tlb_pkg::tlb_miss_t miss_o,
	output logic miss_v_o,
	input logic miss_ack_i,
	output logic rst_busy_o
);

	localparam int IDX_W = $clog2(TLB_SETS);
	localparam int WAY_W = (TLB_WAYS > 1) ? $clog2(TLB_WAYS) : 1;

	logic rst_wr_en;
	logic [IDX_W-1:0] rst_wr_index;
	logic apb_wr_en;
	logic [WAY_W-1:0] apb_wr_way;
	logic [IDX_W-1:0] apb_rd_index, apb_wr_index;
	tlb_pkg::tlb_entry_t apb_wr;
	logic wb_en;
	logic [WAY_W-1:0] wb_way;
	logic [IDX_W-1:0] lk_rd_index, wb_index, rd_index;
	tlb_pkg::tlb_entry_t wb;
	tlb_pkg::tlb_entry_t [TLB_WAYS-1:0] way_rd;  // Registered outputs of all ways
	tlb_pkg::tlb_miss_t lk_miss;
	logic lk_miss_v, q_ready;
	logic [1:0] in_flight;

	assign req_ready_o = ~rst_busy_o & q_ready;  // No lookups while sets are being cleared
	assign rd_index = paging_en_i ? lk_rd_index : apb_rd_index;

	tlb_reset_machine #(.TLB_SETS(TLB_SETS)) u_rst (
		.clk(clk), .rst_i(rst_i), .busy_o(rst_busy_o),
		.wr_en_o(rst_wr_en), .wr_index_o(rst_wr_index)
	);

	tlb_apb_regs #(.TLB_SETS(TLB_SETS), .TLB_WAYS(TLB_WAYS)) u_regs (
		.clk(clk), .rst_i(rst_i), .apb_i(apb_i), .apb_o(apb_o),
		.busy_i(rst_busy_o), .paging_en_i(paging_en_i),
		.rd_index_o(apb_rd_index), .rd_i(way_rd),
		.wr_en_o(apb_wr_en), .wr_way_o(apb_wr_way), .wr_index_o(apb_wr_index), .wr_o(apb_wr)
	);

	tlb_lookup #(.TLB_SETS(TLB_SETS), .TLB_WAYS(TLB_WAYS)) u_lookup (
		.clk(clk), .rst_i(rst_i), .paging_en_i(paging_en_i),
		.req_i(req_i), .req_v_i(req_v_i & req_ready_o),
		.rd_index_o(lk_rd_index), .rd_i(way_rd),
		.res_o(res_o), .res_v_o(res_v_o), .miss_o(lk_miss), .miss_v_o(lk_miss_v),
		.wb_en_o(wb_en), .wb_way_o(wb_way), .wb_index_o(wb_index), .wb_o(wb),
		.in_flight_o(in_flight)
	);

	tlb_miss_queue #(.MISS_DEPTH(MISS_DEPTH)) u_missq (
		.clk(clk), .rst_i(rst_i), .push_i(lk_miss_v), .miss_i(lk_miss),
		.in_flight_i(in_flight), .ready_o(q_ready),
		.miss_o(miss_o), .miss_v_o(miss_v_o), .miss_ack_i(miss_ack_i)
	);

	// =====================================================================
	// Way array with per-way write arbitration
	// =====================================================================

	for (genvar g = 0; g < TLB_WAYS; g++)
	begin : g_way
		logic wr_en;
		logic [IDX_W-1:0] wr_index;
		tlb_pkg::tlb_entry_t wr_data;

		// Reset clear first, then software, then the flag write-back
		always_comb
		begin
			wr_en = 1'b1;
			wr_index = rst_wr_index;
			wr_data = '0;  // All-invalid entry
			if (!rst_wr_en)
			begin
				if (apb_wr_en && apb_wr_way == WAY_W'(g))
				begin
					wr_index = apb_wr_index;
					wr_data = apb_wr;
				end
				else
				begin
					wr_en = wb_en && (wb_way == WAY_W'(g));  // Dropped when it loses
					wr_index = wb_index;
					wr_data = wb;
				end
			end
		end

		tlb_way_ram #(.TLB_SETS(TLB_SETS)) u_ram (
			.clk(clk), .rd_en_i(~rst_busy_o), .rd_index_i(rd_index), .rd_o(way_rd[g]),
			.wr_en_i(wr_en), .wr_index_i(wr_index), .wr_i(wr_data)
		);
	end

endmodule

// File: rtl/tlb_apb_regs.sv
`timescale 1ns/1ps

// APB slave holding one staged entry and the command register
module tlb_apb_regs #(
	parameter int TLB_SETS = 16,
	parameter int TLB_WAYS = 2,
	localparam int IDX_W = $clog2(TLB_SETS),
	localparam int WAY_W = (TLB_WAYS > 1) ? $clog2(TLB_WAYS) : 1
) (
	input logic clk,
	input logic rst_i,
	input tlb_pkg::apb_req_t apb_i,
	output tlb_pkg::apb_rsp_t apb_o,
	input logic busy_i,
	input logic paging_en_i,
	output logic [IDX_W-1:0] rd_index_o,
	input tlb_pkg::tlb_entry_t [TLB_WAYS-1:0] rd_i,
	output logic wr_en_o,
	output logic [WAY_W-1:0] wr_way_o,
	output logic [IDX_W-1:0] wr_index_o,
	output tlb_pkg::tlb_entry_t wr_o
);

	tlb_pkg::tlb_entry_t stage_q;  // Entry staged for a write or loaded by a read
	logic rd_pend_q;               // Way RAM was read, staging loads this cycle
	logic access, done, wr_cmd, rd_cmd;
	logic [WAY_W-1:0] way_sel;

	assign access = apb_i.psel & apb_i.penable;
	assign wr_cmd = apb_i.pwrite & (apb_i.paddr == tlb_pkg::REG_CMD) & apb_i.pwdata[31];
	assign rd_cmd = apb_i.pwrite & (apb_i.paddr == tlb_pkg::REG_CMD) & ~apb_i.pwdata[31]
		& apb_i.pwdata[30];  // Write wins when both bits are set
	assign way_sel = apb_i.pwdata[WAY_W-1:0];  // Held stable through the access

	// A read command with paging off needs a second cycle for the RAM output
	assign done = access & ~busy_i & ~(rd_cmd & ~paging_en_i & ~rd_pend_q);
	assign apb_o.pready = done;
	assign apb_o.pslverr = done & rd_cmd & paging_en_i;  // Read port belongs to lookups

	// =====================================================================
	// Staging registers
	// =====================================================================

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			stage_q <= '0;
			rd_pend_q <= 1'b0;
		end
		else
		begin
			rd_pend_q <= access & rd_cmd & ~paging_en_i & ~busy_i & ~rd_pend_q;
			if (done & rd_pend_q)
				stage_q <= rd_i[way_sel];  // Second access cycle of a read command
			else if (done & apb_i.pwrite)
			begin
				case (apb_i.paddr)
					tlb_pkg::REG_VPN: stage_q.vpn <= apb_i.pwdata[19:0];
					tlb_pkg::REG_PPN:
					begin
						stage_q.pte.ppn <= apb_i.pwdata[19:0];
						{stage_q.pte.v, stage_q.pte.g, stage_q.pte.a, stage_q.pte.m}
							<= apb_i.pwdata[31:28];
					end
					tlb_pkg::REG_ASID: stage_q.asid <= apb_i.pwdata[7:0];
					default: ;  // CMD holds no state of its own
				endcase
			end
		end
	end

	always_comb
	begin
		case (apb_i.paddr)
			tlb_pkg::REG_VPN: apb_o.prdata = {12'b0, stage_q.vpn};
			tlb_pkg::REG_PPN: apb_o.prdata = {stage_q.pte.v, stage_q.pte.g, stage_q.pte.a,
				stage_q.pte.m, 8'b0, stage_q.pte.ppn};
			tlb_pkg::REG_ASID: apb_o.prdata = {24'b0, stage_q.asid};
			default: apb_o.prdata = {31'b0, busy_i};  // CMD reports the clear in progress
		endcase
	end

	// Both commands address the set given by the staged vpn
	assign rd_index_o = stage_q.vpn[IDX_W-1:0];
	assign wr_index_o = stage_q.vpn[IDX_W-1:0];
	assign wr_en_o = access & wr_cmd & ~busy_i;
	assign wr_way_o = way_sel;
	assign wr_o = stage_q;

endmodule

// File: rtl/tlb_lookup.sv
`timescale 1ns/1ps

// Two-stage lookup pipeline
module tlb_lookup #(
	parameter int TLB_SETS = 16,
	parameter int TLB_WAYS = 2,
	localparam int IDX_W = $clog2(TLB_SETS),
	localparam int WAY_W = (TLB_WAYS > 1) ? $clog2(TLB_WAYS) : 1
) (
	input logic clk,
	input logic rst_i,
	input logic paging_en_i,
	input tlb_pkg::tlb_req_t req_i,
	input logic req_v_i,  // Already qualified with ready by the top level
	output logic [IDX_W-1:0] rd_index_o,
	input tlb_pkg::tlb_entry_t [TLB_WAYS-1:0] rd_i,
	output tlb_pkg::tlb_res_t res_o,
	output logic res_v_o,
	output tlb_pkg::tlb_miss_t miss_o,
	output logic miss_v_o,
	output logic wb_en_o,
	output logic [WAY_W-1:0] wb_way_o,
	output logic [IDX_W-1:0] wb_index_o,
	output tlb_pkg::tlb_entry_t wb_o,
	output logic [1:0] in_flight_o
);

	localparam int VA_W = $bits(tlb_pkg::vadr_t);

	tlb_pkg::tlb_req_t s1_req, s2_req;
	logic s1_v, s2_v;
	tlb_pkg::tlb_entry_t [TLB_WAYS-1:0] s2_ways;  // Way outputs captured with the request
	tlb_pkg::vpn_t s2_vpn;
	logic [TLB_WAYS-1:0] hit;
	logic hit_any;
	logic [WAY_W-1:0] hit_way;
	tlb_pkg::tlb_entry_t hit_entry;

	// The ways are read on the accept edge
	assign rd_index_o = req_i.vadr[tlb_pkg::PAGE_BITS +: IDX_W];

	// =====================================================================
	// Pipeline registers
	// =====================================================================

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			s1_v <= 1'b0;
			s2_v <= 1'b0;
			res_v_o <= 1'b0;
		end
		else
		begin
			s1_v <= req_v_i;
			s2_v <= s1_v;
			res_v_o <= s2_v & (hit_any | ~paging_en_i);  // Misses go to the queue instead
		end
	end

	always_ff @(posedge clk)
	begin
		s1_req <= req_i;
		s2_req <= s1_req;
		s2_ways <= rd_i;
		res_o.id <= s2_req.id;
		// Identity mapping while paging is off
		res_o.padr <= paging_en_i ? {hit_entry.pte.ppn, s2_req.vadr[tlb_pkg::PAGE_BITS-1:0]}
			: s2_req.vadr;
	end

	// =====================================================================
	// Tag compare
	// =====================================================================

	assign s2_vpn = s2_req.vadr[VA_W-1:tlb_pkg::PAGE_BITS];

	always_comb
	begin
		hit_any = 1'b0;
		hit_way = '0;
		hit_entry = s2_ways[0];
		for (int w = TLB_WAYS - 1; w >= 0; w--)
		begin
			hit[w] = s2_ways[w].pte.v && (s2_ways[w].vpn == s2_vpn)
				&& (s2_ways[w].pte.g || (s2_ways[w].asid == s2_req.asid));
			if (hit[w])  // Descending loop leaves the lowest hitting way
			begin
				hit_any = 1'b1;
				hit_way = WAY_W'(w);
				hit_entry = s2_ways[w];
			end
		end
	end

	assign miss_v_o = s2_v & paging_en_i & ~hit_any;
	assign miss_o.vadr = s2_req.vadr;
	assign miss_o.asid = s2_req.asid;
	assign miss_o.id = s2_req.id;

	// Flag update goes back to the way that hit, on the same edge as the result
	always_comb
	begin
		wb_o = hit_entry;
		wb_o.pte.a = 1'b1;
		wb_o.pte.m = hit_entry.pte.m | s2_req.store;
	end
	assign wb_en_o = s2_v & paging_en_i & hit_any;
	assign wb_way_o = hit_way;
	assign wb_index_o = s2_vpn[IDX_W-1:0];

	assign in_flight_o = {1'b0, s1_v} + {1'b0, s2_v};

endmodule

// File: rtl/tlb_miss_queue.sv
`timescale 1ns/1ps

// FIFO of lookups that missed, waiting for the walker
module tlb_miss_queue #(
	parameter int MISS_DEPTH = 4,
	localparam int PTR_W = $clog2(MISS_DEPTH),
	localparam int CNT_W = PTR_W + 1
) (
	input logic clk,
	input logic rst_i,
	input logic push_i,
	input tlb_pkg::tlb_miss_t miss_i,
	input logic [1:0] in_flight_i,
	output logic ready_o,
	output tlb_pkg::tlb_miss_t miss_o,
	output logic miss_v_o,
	input logic miss_ack_i
);

	tlb_pkg::tlb_miss_t mem [MISS_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;  // Wrap on their own since the depth is a power of two
	logic [CNT_W-1:0] count, free;
	logic pop;

	assign pop = miss_ack_i & miss_v_o;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + CNT_W'(push_i) - CNT_W'(pop);
		end
	end

	always_ff @(posedge clk)
	begin
		if (push_i)
			mem[wr_ptr] <= miss_i;
	end

	assign miss_o = mem[rd_ptr];  // Head of queue
	assign miss_v_o = (count != '0);

	// Room for every lookup in flight plus the one being offered
	assign free = CNT_W'(MISS_DEPTH) - count;
	assign ready_o = (free > CNT_W'(in_flight_i));

endmodule

// File: rtl/tlb_pkg.sv
package tlb_pkg;

	// =====================================================================
	// Address widths
	// =====================================================================

	localparam int PAGE_BITS = 12;  // 4 KiB pages

	typedef logic [31:0] vadr_t;  // Virtual address
	typedef logic [31:0] padr_t;  // Physical address
	typedef logic [19:0] vpn_t;   // Virtual page number, bits 31:12 of vadr_t
	typedef logic [19:0] ppn_t;   // Physical page number
	typedef logic [7:0] asid_t;   // Address space id
	typedef logic [7:0] req_id_t; // Tag that travels with a lookup

	// =====================================================================
	// Entry layout
	// =====================================================================

	// Flags sit above the ppn, in the same order as bits 31:28 of the PPN register
	typedef struct packed {
		logic v;  // Entry holds a valid translation
		logic g;  // Global page, matches any asid
		logic a;  // Accessed since last cleared by software
		logic m;  // Modified by a store
		ppn_t ppn;
	} tlb_pte_t;

	typedef struct packed {
		vpn_t vpn;  // Full vpn is kept so read-back needs no set index
		asid_t asid;
		tlb_pte_t pte;
	} tlb_entry_t;

	// Lookup side
	typedef struct packed {
		vadr_t vadr;
		asid_t asid;
		req_id_t id;
		logic store;  // A store sets the modified flag on a hit
	} tlb_req_t;

	typedef struct packed {
		padr_t padr;
		req_id_t id;
	} tlb_res_t;

	typedef struct packed {
		vadr_t vadr;
		asid_t asid;
		req_id_t id;
	} tlb_miss_t;

	// =====================================================================
	// Register window
	// =====================================================================

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [3:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	localparam logic [3:0] REG_VPN = 4'd0;
	localparam logic [3:0] REG_PPN = 4'd4;
	localparam logic [3:0] REG_ASID = 4'd8;
	localparam logic [3:0] REG_CMD = 4'd12;

	typedef enum logic [1:0] {IDLE, CLEAR, DONE} rst_state_t;

endpackage

// File: rtl/tlb_reset_machine.sv
`timescale 1ns/1ps

// Clears every set of every way after reset
module tlb_reset_machine #(
	parameter int TLB_SETS = 16,
	localparam int IDX_W = $clog2(TLB_SETS)
) (
	input logic clk,
	input logic rst_i,
	output logic busy_o,
	output logic wr_en_o,
	output logic [IDX_W-1:0] wr_index_o
);

	localparam logic [IDX_W-1:0] LAST = IDX_W'(TLB_SETS - 1);

	tlb_pkg::rst_state_t state;
	logic [IDX_W-1:0] cnt;  // Set being cleared this cycle

	// IDLE is the state left by reset and already clears set 0,
	// so the machine is busy for exactly TLB_SETS cycles
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			state <= tlb_pkg::IDLE;
			cnt <= '0;
		end
		else
		begin
			case (state)
				tlb_pkg::IDLE, tlb_pkg::CLEAR:
				begin
					cnt <= cnt + 1'b1;
					state <= (cnt == LAST) ? tlb_pkg::DONE : tlb_pkg::CLEAR;
				end
				default: state <= tlb_pkg::DONE;  // Stays here until the next reset
			endcase
		end
	end

	assign busy_o = (state != tlb_pkg::DONE);
	assign wr_en_o = busy_o;   // Every busy cycle writes one set
	assign wr_index_o = cnt;

endmodule

// File: rtl/tlb_way_ram.sv
`timescale 1ns/1ps

// Entry store for one way of the TLB
module tlb_way_ram #(
	parameter int TLB_SETS = 16,
	localparam int IDX_W = $clog2(TLB_SETS)
) (
	input logic clk,
	input logic rd_en_i,
	input logic [IDX_W-1:0] rd_index_i,
	output tlb_pkg::tlb_entry_t rd_o,
	input logic wr_en_i,
	input logic [IDX_W-1:0] wr_index_i,
	input tlb_pkg::tlb_entry_t wr_i
);

	tlb_pkg::tlb_entry_t mem [TLB_SETS];  // One entry per set

	// Both ports sit in one process so a same-index access reads the old entry
	always_ff @(posedge clk)
	begin
		if (rd_en_i)
		begin
			rd_o <= mem[rd_index_i];  // Registered read, valid one cycle later
		end
		if (wr_en_i)
		begin
			mem[wr_index_i] <= wr_i;
		end
	end

endmodule

// File: tests/tlb_tb.sv
`timescale 1ns/1ps

module tlb_tb;

	localparam int SETS = 16;
	localparam int WAYS = 2;
	localparam int IDX_W = $clog2(SETS);
	localparam int LIMIT = 200;  // Cycles allowed for any single wait
	localparam logic [2:0] OP_WR = 3'd0;    // APB write, exp[0] is the expected pslverr
	localparam logic [2:0] OP_RD = 3'd1;    // APB read, exp is the expected prdata
	localparam logic [2:0] OP_CHK = 3'd2;   // Read command on data way/set, entry vs model
	localparam logic [2:0] OP_LK = 3'd3;    // Lookup, result predicted by the model
	localparam logic [2:0] OP_POP = 3'd4;   // Pop one miss and compare with the model
	localparam logic [2:0] OP_RDY = 3'd5;   // Drain, then exp[1:0] is {req_ready, miss_v}
	localparam logic [2:0] OP_PAGE = 3'd6;  // Drain, then set paging_en_i to data[0]

	typedef struct packed {
		logic [2:0] op;
		logic [3:0] test;
		logic [3:0] addr;
		logic [31:0] data;
		logic [31:0] exp;
		tlb_pkg::tlb_req_t req;
	} row_t;

	logic clk, rst_i, paging_en_i, req_v_i, req_ready_o, res_v_o, miss_v_o, miss_ack_i;
	logic rst_busy_o;
	tlb_pkg::apb_req_t apb_i;
	tlb_pkg::apb_rsp_t apb_o;
	tlb_pkg::tlb_req_t req_i;
	tlb_pkg::tlb_res_t res_o;
	tlb_pkg::tlb_miss_t miss_o;

	// Reference model of the way array and the staging registers
	tlb_pkg::tlb_entry_t ref_mem [WAYS][SETS];
	tlb_pkg::tlb_entry_t stage_m;
	tlb_pkg::tlb_res_t res_exp_q [$];
	int res_due_q [$];  // Cycle in which each expected result must be visible
	int due_q [$];      // One entry per lookup in flight
	tlb_pkg::tlb_miss_t miss_exp_q [$];
	int cyc = 0;
	int err_cnt, test_err_base, cur_test, n_pass, n_fail, n_rows;
	logic timed_out;
	logic [31:0] lfsr;
	row_t rows [128];

	tlb #(.TLB_SETS(SETS), .TLB_WAYS(WAYS), .MISS_DEPTH(4)) uut (
		.clk(clk), .rst_i(rst_i), .apb_i(apb_i), .apb_o(apb_o), .paging_en_i(paging_en_i),
		.req_i(req_i), .req_v_i(req_v_i), .req_ready_o(req_ready_o), .res_o(res_o),
		.res_v_o(res_v_o), .miss_o(miss_o), .miss_v_o(miss_v_o), .miss_ack_i(miss_ack_i),
		.rst_busy_o(rst_busy_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns period
	end

	always @(posedge clk) cyc <= cyc + 1;

	// ======================================================================
	// Helpers
	// ======================================================================

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois form, taps 32 22 2 1
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);  // One step per bit taken
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic string test_label(input int t);
		case (t)
			0: return "reset";
			1: return "clear_after_reset";
			2: return "write_readback";
			3: return "hit_back_to_back";
			4: return "asid_global";
			5: return "miss_queue";
			6: return "access_flags";
			7: return "identity";
			default: return "read_cmd_pslverr";
		endcase
	endfunction

	task automatic note_failure(input string msg);
		$display("%s: %s", test_label(cur_test), msg);
		err_cnt++;
	endtask

	task automatic note_timeout(input string what);
		$display("%s: timed out waiting for %s", test_label(cur_test), what);
		err_cnt++;
		timed_out = 1'b1;  // Main loop stops at the next row
	endtask

	task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp)
		begin
			$display("[ERROR] %s: expected %h, actual %h", what, exp, got);
			err_cnt++;
		end
	endtask

	task automatic check_res(input string what, input tlb_pkg::tlb_res_t exp,
			input tlb_pkg::tlb_res_t got);
		if (got !== exp)
		begin
			$display("[ERROR] %s: expected padr %h id %h, actual padr %h id %h", what,
				exp.padr, exp.id, got.padr, got.id);
			err_cnt++;
		end
	endtask

	task automatic check_miss(input string what, input tlb_pkg::tlb_miss_t exp,
			input tlb_pkg::tlb_miss_t got);
		if (got !== exp)
		begin
			$display("[ERROR] %s: expected miss %h, actual miss %h", what, exp, got);
			err_cnt++;
		end
	endtask

	task automatic check_entry(input string what, input tlb_pkg::tlb_entry_t exp,
			input tlb_pkg::tlb_entry_t got);
		if (got !== exp)
		begin
			$display("[ERROR] %s: expected entry %h, actual entry %h", what, exp, got);
			err_cnt++;
		end
	endtask

	// ======================================================================
	// Bus and lookup drivers
	// ======================================================================

	// Setup phase, then access phase until pready, all driven 1 ns after the edge
	task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] data,
			output logic [31:0] rdata, output logic err);
		int t;
		@(posedge clk);
		#1;
		apb_i.psel = 1'b1;
		apb_i.pwrite = wr;
		apb_i.paddr = addr;
		apb_i.pwdata = data;
		@(posedge clk);
		#1;
		apb_i.penable = 1'b1;
		t = 0;
		@(negedge clk);
		while (!apb_o.pready && t < LIMIT)
		begin
			@(negedge clk);
			t++;
		end
		if (!apb_o.pready)
			note_timeout("APB pready");
		rdata = apb_o.prdata;
		err = apb_o.pslverr;
		@(posedge clk);  // Transfer completes on this edge
		#1;
		apb_i = '0;
	endtask

	// Register write that also keeps the staging and way model up to date
	task automatic reg_write(input logic [3:0] addr, input logic [31:0] data,
			input logic exp_err);
		logic [31:0] rdata;
		logic err;
		apb_xfer(1'b1, addr, data, rdata, err);
		check_word({test_label(cur_test), " pslverr"}, {31'b0, exp_err}, {31'b0, err});
		case (addr)
			tlb_pkg::REG_VPN: stage_m.vpn = data[19:0];
			tlb_pkg::REG_PPN:
			begin
				stage_m.pte.ppn = data[19:0];
				{stage_m.pte.v, stage_m.pte.g, stage_m.pte.a, stage_m.pte.m} = data[31:28];
			end
			tlb_pkg::REG_ASID: stage_m.asid = data[7:0];
			default:
			begin
				if (data[31])
					ref_mem[data[0]][stage_m.vpn[IDX_W-1:0]] = stage_m;
				else if (data[30] && !paging_en_i)
					stage_m = ref_mem[data[0]][stage_m.vpn[IDX_W-1:0]];  // Read command
			end
		endcase
	endtask

	task automatic entry_check(input int way, input int set);
		logic [31:0] vpn_r, ppn_r, asid_r;
		logic err;
		tlb_pkg::tlb_entry_t got;
		reg_write(tlb_pkg::REG_VPN, set, 1'b0);  // Only the index bits pick the set
		reg_write(tlb_pkg::REG_CMD, 32'h4000_0000 | way, 1'b0);
		apb_xfer(1'b0, tlb_pkg::REG_VPN, '0, vpn_r, err);
		apb_xfer(1'b0, tlb_pkg::REG_PPN, '0, ppn_r, err);
		apb_xfer(1'b0, tlb_pkg::REG_ASID, '0, asid_r, err);
		got.vpn = vpn_r[19:0];
		got.asid = asid_r[7:0];
		got.pte.ppn = ppn_r[19:0];
		{got.pte.v, got.pte.g, got.pte.a, got.pte.m} = ppn_r[31:28];
		check_entry($sformatf("%s way %0d set %0d", test_label(cur_test), way, set),
			ref_mem[way][set], got);
	endtask

	// Leaves req_v_i low after the accept edge, so a following call is back to back
	task automatic issue_lookup(input tlb_pkg::tlb_req_t r);
		int t;
		req_i = r;
		req_v_i = 1'b1;
		t = 0;
		@(negedge clk);
		while (!req_ready_o && t < LIMIT)
		begin
			@(negedge clk);
			t++;
		end
		if (!req_ready_o)
			note_timeout("req_ready_o");
		@(posedge clk);
		#1;
		req_v_i = 1'b0;
	endtask

	task automatic pop_miss();
		int t;
		t = 0;
		@(negedge clk);
		while (!miss_v_o && t < LIMIT)
		begin
			@(negedge clk);
			t++;
		end
		if (!miss_v_o)
			note_timeout("miss_v_o");
		else
		begin
			@(posedge clk);
			#1;
			miss_ack_i = 1'b1;
			@(negedge clk);
			if (miss_exp_q.size() == 0)
				note_failure("a miss was popped while none was expected");
			else
				check_miss(test_label(cur_test), miss_exp_q.pop_front(), miss_o);
			@(posedge clk);  // Pop happens on this edge
			#1;
			miss_ack_i = 1'b0;
		end
	endtask

	task automatic drain_lookups();
		int t;
		t = 0;
		while (due_q.size() != 0 && t < LIMIT)
		begin
			@(posedge clk);
			#1;
			t++;
		end
		if (due_q.size() != 0)
			note_timeout("lookups in flight to finish");
	endtask

	// Hit rules: valid, vpn equal, global or same asid; lowest way wins
	task automatic predict_lookup(input tlb_pkg::tlb_req_t r);
		tlb_pkg::tlb_res_t exp;
		int set, hw;
		set = r.vadr[tlb_pkg::PAGE_BITS +: IDX_W];
		hw = -1;
		for (int w = 0; w < WAYS; w++)
			if (hw < 0 && ref_mem[w][set].pte.v && ref_mem[w][set].vpn == r.vadr[31:12]
					&& (ref_mem[w][set].pte.g || ref_mem[w][set].asid == r.asid))
				hw = w;
		due_q.push_back(cyc + 3);  // Visible after the second edge past acceptance
		exp.id = r.id;
		exp.padr = r.vadr;
		if (paging_en_i && hw >= 0)
		begin
			exp.padr = {ref_mem[hw][set].pte.ppn, r.vadr[tlb_pkg::PAGE_BITS-1:0]};
			ref_mem[hw][set].pte.a = 1'b1;
			ref_mem[hw][set].pte.m = ref_mem[hw][set].pte.m | r.store;
		end
		if (paging_en_i && hw < 0)
			miss_exp_q.push_back({r.vadr, r.asid, r.id});
		else
		begin
			res_exp_q.push_back(exp);
			res_due_q.push_back(cyc + 3);
		end
	endtask

	// Result checker, sampling halfway through each cycle
	always @(negedge clk)
	begin
		if (!rst_i)
		begin
			if (res_v_o)
			begin
				if (res_exp_q.size() == 0)
					note_failure("a result appeared with no matching lookup");
				else
				begin
					if (res_due_q[0] != cyc)
						note_failure("a result did not arrive two cycles after acceptance");
					check_res(test_label(cur_test), res_exp_q.pop_front(), res_o);
					void'(res_due_q.pop_front());
				end
			end
			else if (res_due_q.size() != 0 && res_due_q[0] <= cyc)
			begin
				note_failure("an expected result never appeared");
				void'(res_exp_q.pop_front());
				void'(res_due_q.pop_front());
			end
			while (due_q.size() != 0 && due_q[0] <= cyc)
				void'(due_q.pop_front());
			if (req_v_i && req_ready_o)
				predict_lookup(req_i);  // Accepted on the coming edge
		end
	end

	// ======================================================================
	// Stimulus table
	// ======================================================================

	task automatic add_row(input logic [2:0] op, input logic [3:0] test,
			input logic [3:0] addr, input logic [31:0] data, input logic [31:0] exp,
			input tlb_pkg::tlb_req_t req);
		rows[n_rows] = {op, test, addr, data, exp, req};
		n_rows++;
	endtask

	task automatic build_table();
		int set [4] = '{3, 3, 9, 12};  // Two entries share set 3 in different ways
		int way [4] = '{0, 1, 1, 0};
		logic [7:0] asid [4] = '{8'h11, 8'h22, 8'h33, 8'h11};
		logic [3:0] flags [4] = '{4'b1000, 4'b1000, 4'b1100, 4'b1000};  // Entry 2 is global
		logic [31:0] vpn [4];
		logic [31:0] ppn [4];
		logic [31:0] r, off;
		for (int i = 0; i < 4; i++)
		begin
			take_bits(16, r);
			vpn[i] = {r[15:0], 4'(set[i])};
			take_bits(20, ppn[i]);
		end
		for (int s = 0; s < SETS; s++)
			for (int w = 0; w < WAYS; w++)
				add_row(OP_CHK, 1, 0, (w << 16) | s, 0, '0);
		add_row(OP_RD, 1, tlb_pkg::REG_CMD, 0, 0, '0);  // Busy bit now clear
		for (int i = 0; i < 4; i++)
		begin
			add_row(OP_WR, 2, tlb_pkg::REG_VPN, vpn[i], 0, '0);
			add_row(OP_WR, 2, tlb_pkg::REG_PPN, {flags[i], 8'b0, ppn[i][19:0]}, 0, '0);
			add_row(OP_WR, 2, tlb_pkg::REG_ASID, asid[i], 0, '0);
			add_row(OP_WR, 2, tlb_pkg::REG_CMD, 32'h8000_0000 | way[i], 0, '0);
			add_row(OP_RD, 2, tlb_pkg::REG_PPN, 0, {flags[i], 8'b0, ppn[i][19:0]}, '0);
		end
		for (int i = 0; i < 4; i++)
			add_row(OP_CHK, 2, 0, (way[i] << 16) | set[i], 0, '0);
		add_row(OP_PAGE, 3, 0, 1, 0, '0);
		for (int i = 0; i < 4; i++)
		begin
			take_bits(12, off);
			add_row(OP_LK, 3, 0, 0, 0, {vpn[i][19:0], off[11:0], asid[i], 8'(i + 1), 1'b0});
		end
		add_row(OP_RDY, 3, 0, 0, 2'b10, '0);
		take_bits(12, off);
		add_row(OP_LK, 4, 0, 0, 0, {vpn[0][19:0], off[11:0], 8'h22, 8'd5, 1'b0});  // Misses
		take_bits(12, off);
		add_row(OP_LK, 4, 0, 0, 0, {vpn[2][19:0], off[11:0], 8'h99, 8'd6, 1'b0});  // Global
		add_row(OP_RDY, 4, 0, 0, 2'b11, '0);
		add_row(OP_POP, 4, 0, 0, 0, '0);
		add_row(OP_RDY, 4, 0, 0, 2'b10, '0);
		for (int k = 0; k < 5; k++)
		begin
			take_bits(16, r);
			take_bits(12, off);
			add_row(OP_LK, 5, 0, 0, 0, {r[15:0], 4'h5, off[11:0], 8'h44, 8'(16 + k), 1'b0});
			if (k == 3)
			begin
				add_row(OP_RDY, 5, 0, 0, 2'b01, '0);  // Queue full, lookups held off
				add_row(OP_POP, 5, 0, 0, 0, '0);
				add_row(OP_RDY, 5, 0, 0, 2'b11, '0);
			end
		end
		add_row(OP_RDY, 5, 0, 0, 2'b01, '0);
		for (int k = 0; k < 4; k++)
			add_row(OP_POP, 5, 0, 0, 0, '0);
		add_row(OP_RDY, 5, 0, 0, 2'b10, '0);
		take_bits(12, off);
		add_row(OP_LK, 6, 0, 0, 0, {vpn[1][19:0], off[11:0], asid[1], 8'd24, 1'b1});  // Store
		add_row(OP_RDY, 6, 0, 0, 2'b10, '0);
		add_row(OP_PAGE, 6, 0, 0, 0, '0);
		for (int i = 0; i < 4; i++)
			add_row(OP_CHK, 6, 0, (way[i] << 16) | set[i], 0, '0);
		take_bits(32, r);
		add_row(OP_LK, 7, 0, 0, 0, {r, 8'h00, 8'd32, 1'b0});
		take_bits(12, off);
		add_row(OP_LK, 7, 0, 0, 0, {vpn[0][19:0], off[11:0], asid[0], 8'd33, 1'b1});
		add_row(OP_RDY, 7, 0, 0, 2'b10, '0);
		add_row(OP_PAGE, 8, 0, 1, 0, '0);
		add_row(OP_WR, 8, tlb_pkg::REG_CMD, 32'h4000_0000, 1, '0);
		add_row(OP_PAGE, 8, 0, 0, 0, '0);
	endtask

	// ======================================================================
	// Sequencing and report
	// ======================================================================

	task automatic check_reset_clear();
		int t;
		t = 0;
		@(negedge clk);
		check_word("reset res_v/miss_v/pready", 0, {res_v_o, miss_v_o, apb_o.pready});
		while (rst_busy_o && t < LIMIT)
		begin
			if (req_ready_o)
				note_failure("req_ready_o was high while the entries were being cleared");
			t++;
			@(negedge clk);
		end
		if (rst_busy_o)
			note_timeout("rst_busy_o to fall");
		else
			check_word("reset busy cycles", SETS, t);  // One cycle per set
		@(posedge clk);
		#1;
	endtask

	task automatic run_row(input row_t r);
		logic [31:0] rdata;
		logic err;
		case (r.op)
			OP_WR: reg_write(r.addr, r.data, r.exp[0]);
			OP_RD:
			begin
				apb_xfer(1'b0, r.addr, '0, rdata, err);
				check_word({test_label(cur_test), " prdata"}, r.exp, rdata);
			end
			OP_CHK: entry_check(r.data[31:16], r.data[15:0]);
			OP_LK: issue_lookup(r.req);
			OP_POP: pop_miss();
			OP_RDY:
			begin
				drain_lookups();
				@(negedge clk);
				check_word({test_label(cur_test), " req_ready/miss_v"}, r.exp,
					{30'b0, req_ready_o, miss_v_o});
				@(posedge clk);
				#1;
			end
			default:
			begin
				drain_lookups();
				paging_en_i = r.data[0];  // Only changed with the pipeline empty
			end
		endcase
	endtask

	task automatic end_test();
		if (err_cnt == test_err_base)
		begin
			$display("PASS %s", test_label(cur_test));
			n_pass++;
		end
		else
		begin
			$display("FAIL %s (%0d errors)", test_label(cur_test), err_cnt - test_err_base);
			n_fail++;
		end
		test_err_base = err_cnt;
	endtask

	initial
	begin
		rst_i = 1'b1;
		paging_en_i = 1'b0;
		req_v_i = 1'b0;
		req_i = '0;
		miss_ack_i = 1'b0;
		apb_i = '0;
		err_cnt = 0;
		test_err_base = 0;
		cur_test = 0;
		n_pass = 0;
		n_fail = 0;
		n_rows = 0;
		timed_out = 1'b0;
		lfsr = 32'hb790;
		stage_m = '0;
		for (int w = 0; w < WAYS; w++)
			for (int s = 0; s < SETS; s++)
				ref_mem[w][s] = '0;  // Reset machine leaves every entry invalid
		build_table();
		repeat (3) @(posedge clk);
		#1;
		rst_i = 1'b0;
		check_reset_clear();
		for (int i = 0; i < n_rows && !timed_out; i++)
		begin
			if (rows[i].test != cur_test)
			begin
				end_test();
				cur_test = rows[i].test;
			end
			run_row(rows[i]);
		end
		end_test();
		$display("Totals: %0d tests passed, %0d tests failed, %0d errors", n_pass, n_fail,
			err_cnt);
		if (err_cnt == 0 && !timed_out)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: verilog.f
rtl/tlb_pkg.sv
rtl/tlb_way_ram.sv
rtl/tlb_reset_machine.sv
rtl/tlb_apb_regs.sv
rtl/tlb_lookup.sv
rtl/tlb_miss_queue.sv
rtl/tlb.sv
tests/tlb_tb.sv
